/* sim.f */
verilog/acore_pkg.sv
verilog/acore_clk_div.sv
verilog/acore_adc_slice.sv
verilog/acore_bus_arb.sv
verilog/analog_core.sv
verif/acore_bus_arb_sva.sv
verif/analog_core_tb.sv

/* Makefile */
# Verilator build and run of the analog core testbench

TOP := analog_core_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf obj_dir

/* verif/analog_core_tb.sv */
module analog_core_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import acore_pkg::*;

    localparam int          NROWS     = 6;
    localparam int          LOG_DEPTH = 1024;
    localparam int          WAIT_MAX  = 200;    // cycles allowed per word
    localparam int          FULL      = (1 << NADC) - 1;
    localparam logic [31:0] SEED      = 32'hd753;

    typedef struct {
        logic [NDIV-1:0]       ndiv;
        logic signed [NIN-1:0] off [NTI];
        int                    nwords;
        bit                    withhold;   // credits held back
    } row_t;

    logic                  clk;
    logic                  rst_i;
    logic                  en_i;
    logic [NDIV-1:0]       ndiv_i;
    logic signed [NIN-1:0] rx_sample_i;
    logic                  cfg_we_i;
    logic [NID-1:0]        cfg_slice_i;
    logic signed [NIN-1:0] cfg_offset_i;
    logic                  credit_i;
    logic [NWORD-1:0]      data_o;
    logic                  valid_o;
    logic                  overrun_o;

    row_t                  rows [NROWS];
    int                    nrows;
    logic signed [NIN-1:0] samp_log [LOG_DEPTH];  // rx sample by cycle from en_i
    logic [31:0]           rng;
    int                    cyc;
    bit                    running;
    logic                  rst_d;
    logic                  we_d;
    logic [NID-1:0]        slice_d;
    logic signed [NIN-1:0] offset_d;
    logic [NDIV-1:0]       ndiv_d;
    logic                  credit_pend;

    analog_core dut0 (
        .ext_clk_i    (clk),
        .rst_i        (rst_i),
        .en_i         (en_i),
        .ndiv_i       (ndiv_i),
        .rx_sample_i  (rx_sample_i),
        .cfg_we_i     (cfg_we_i),
        .cfg_slice_i  (cfg_slice_i),
        .cfg_offset_i (cfg_offset_i),
        .credit_i     (credit_i),
        .data_o       (data_o),
        .valid_o      (valid_o),
        .overrun_o    (overrun_o)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x;
        y = y ^ (y << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // reference quantizer, magnitude capped at full scale
    task automatic expected_code(input logic signed [NIN-1:0] s, input logic signed [NIN-1:0] o,
                                 output logic sgn, output logic [NADC-1:0] mag);
        int d;
        int a;
        d   = int'(s) - int'(o);
        a   = (d < 0) ? -d : d;
        sgn = (d < 0);
        mag = (a > FULL) ? NADC'(FULL) : NADC'(a);
    endtask

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_word(input logic [NID-1:0] id, input logic sgn,
                              input logic [NADC-1:0] mag);
        logic [NID-1:0]  got_id;
        logic            got_sgn;
        logic [NADC-1:0] got_mag;
        got_id  = data_o[W_ID_MSB:W_ID_LSB];
        got_sgn = data_o[W_SIGN_BIT];
        got_mag = data_o[W_SIGN_BIT-1:W_MAG_LSB];
        if (got_id !== id || got_sgn !== sgn || got_mag !== mag) begin
            abort_run($sformatf("FAILED at %0t: word id/sign/mag %0d/%0b/%0d, expected %0d/%0b/%0d",
                                $time, got_id, got_sgn, got_mag, id, sgn, mag));
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("FAILED at %0t: %s is %b, expected %b", $time, what, got, exp));
        end
    endtask

    task automatic check_latency(input int got, input int exp);
        if (got != exp) begin
            abort_run($sformatf("FAILED at %0t: word arrived in cycle %0d, expected cycle %0d",
                                $time, got, exp));
        end
    endtask

    // one clock: drive on the rising edge, outputs read at the falling edge
    task automatic tick();
        @(posedge clk);
        cyc = cyc + 1;
        rng = xorshift(rng);
        rx_sample_i  <= rng[NIN-1:0];
        rst_i        <= rst_d;
        en_i         <= running;
        ndiv_i       <= ndiv_d;
        cfg_we_i     <= we_d;
        cfg_slice_i  <= slice_d;
        cfg_offset_i <= offset_d;
        credit_i     <= credit_pend;   // one cycle pulse
        credit_pend = 1'b0;
        if (running && cyc >= 0 && cyc < LOG_DEPTH) begin
            samp_log[cyc] = rng[NIN-1:0];
        end
        @(negedge clk);
    endtask

    task automatic wait_valid(input string what);
        int  n;
        bit  seen;
        n    = 0;
        seen = 1'b0;
        while (!seen && n < WAIT_MAX) begin
            tick();
            seen = (valid_o === 1'b1);
            n++;
        end
        if (!seen) begin
            abort_run($sformatf("timeout: no valid word within %0d cycles while %s",
                                WAIT_MAX, what));
        end
    endtask

    task automatic add_row(input int nd, input int o0, input int o1, input int o2,
                           input int o3, input int nw, input bit wh);
        rows[nrows].ndiv     = NDIV'(nd);
        rows[nrows].off[0]   = NIN'(o0);
        rows[nrows].off[1]   = NIN'(o1);
        rows[nrows].off[2]   = NIN'(o2);
        rows[nrows].off[3]   = NIN'(o3);
        rows[nrows].nwords   = nw;
        rows[nrows].withhold = wh;
        nrows++;
    endtask

    task automatic reset_dut(input logic [NDIV-1:0] nd);
        rst_d       = 1'b1;
        running     = 1'b0;
        credit_pend = 1'b0;
        ndiv_d      = nd;
        repeat (16) tick();
        rst_d = 1'b0;
        tick();
        check_flag(valid_o, 1'b0, "valid_o after reset");
        check_flag(overrun_o, 1'b0, "overrun_o after reset");
    endtask

    task automatic write_offsets(input int ri);
        int k;
        for (k = 0; k < NTI; k++) begin
            we_d     = 1'b1;
            slice_d  = NID'(k);
            offset_d = rows[ri].off[k];
            tick();
        end
        we_d = 1'b0;
    endtask

    task automatic run_prompt(input int ri, input int n);
        int              w;
        int              sc;
        int              id;
        logic            sgn;
        logic [NADC-1:0] mag;
        for (w = 0; w < rows[ri].nwords; w++) begin
            wait_valid("waiting for a prompt-credit word");
            sc = n * (w + 1);              // strobe cycle of word w
            id = w % NTI;
            check_latency(cyc, sc + 2);
            expected_code(samp_log[sc], rows[ri].off[id], sgn, mag);
            check_word(NID'(id), sgn, mag);
            check_flag(overrun_o, 1'b0, "overrun_o with prompt credits");
            credit_pend = 1'b1;
        end
    endtask

    task automatic run_withhold(input int ri, input int n);
        int              ovr_cyc;
        int              last;
        int              words;
        int              sc;
        int              id;
        int              k;
        logic            sgn;
        logic [NADC-1:0] mag;
        // slices refill after the stall, the next round of strobes is dropped
        ovr_cyc = n * (NCRED + NTI + 1) + 1;
        last    = ovr_cyc + 2 * n + 4;
        words   = 0;
        while (cyc < last) begin
            tick();
            if (valid_o === 1'b1) begin
                if (words >= NCRED) begin
                    abort_run($sformatf("FAILED at %0t: valid_o high with no credit left", $time));
                end
                sc = n * (words + 1);
                check_latency(cyc, sc + 2);
                expected_code(samp_log[sc], rows[ri].off[words % NTI], sgn, mag);
                check_word(NID'(words % NTI), sgn, mag);
                words++;
            end
            check_flag(overrun_o, (cyc >= ovr_cyc), "overrun_o while credits are withheld");
        end
        if (words != rows[ri].nwords) begin
            abort_run($sformatf("only %0d of %0d words appeared before the credit stall",
                                words, rows[ri].nwords));
        end
        running = 1'b0;                    // no more strobes while draining
        for (k = 0; k < NTI; k++) begin
            credit_pend = 1'b1;
            wait_valid("draining the held words");
            id = (NCRED + k) % NTI;
            sc = n * (NCRED + k + 1);
            expected_code(samp_log[sc], rows[ri].off[id], sgn, mag);
            check_word(NID'(id), sgn, mag);
            check_flag(overrun_o, 1'b1, "overrun_o while draining");
        end
        for (k = 0; k < 2 * NTI; k++) begin
            tick();
            check_flag(valid_o, 1'b0, "valid_o after the drain");
            check_flag(overrun_o, 1'b1, "overrun_o after the drain");
        end
    endtask

    task automatic apply_row(input int ri);
        int n;
        n = (rows[ri].ndiv == '0) ? 1 : int'(rows[ri].ndiv);
        reset_dut(rows[ri].ndiv);
        write_offsets(ri);
        cyc     = -1;
        running = 1'b1;
        tick();                            // cycle 0, en_i goes high
        if (rows[ri].withhold) begin
            run_withhold(ri, n);
        end else begin
            run_prompt(ri, n);
        end
    endtask

    initial begin
        rst_i        = 1'b1;
        en_i         = 1'b0;
        ndiv_i       = '0;
        rx_sample_i  = '0;
        cfg_we_i     = 1'b0;
        cfg_slice_i  = '0;
        cfg_offset_i = '0;
        credit_i     = 1'b0;
        rng          = SEED;
        cyc          = 0;
        running      = 1'b0;
        rst_d        = 1'b1;
        we_d         = 1'b0;
        slice_d      = '0;
        offset_d     = '0;
        ndiv_d       = '0;
        credit_pend  = 1'b0;
        nrows        = 0;
        //      ndiv  off0   off1   off2   off3  words  withhold
        add_row(1,       0,    20,   -35,   100,    12, 1'b0);
        add_row(3,    -256,   255,     0,     7,    12, 1'b0);  // both saturation ends
        add_row(2,       5,    -5,    64,   -64, NCRED, 1'b1);
        add_row(0,     255,  -256,     1,    -1,    12, 1'b0);  // 0 acts as 1
        add_row(1,       0,     0,     0,     0, NCRED, 1'b1);
        add_row(3,      10,  -128,   127,  -200,     8, 1'b0);
        for (int r = 0; r < nrows; r++) begin
            apply_row(r);
        end
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

/* verif/acore_bus_arb_sva.sv */
module acore_bus_arb_sva (
    input  logic                         clk_i,
    input  logic                         rst_i,
    input  logic [acore_pkg::NTI-1:0]    grant_i,
    input  logic                         valid_i,
    input  logic                         credit_i,
    input  logic [acore_pkg::NCNT-1:0]   cnt_i
);
    timeunit 1ns;
    timeprecision 1ps;
    import acore_pkg::*;

    logic [NCNT-1:0] held_q;   // words out on the bus, not yet credited back

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            held_q <= '0;
        end else begin
            held_q <= held_q + NCNT'(valid_i) - NCNT'(credit_i);
        end
    end

    grant_onehot: assert property (@(posedge clk_i) disable iff (rst_i)
        $onehot0(grant_i))
        else $error("grant_o is neither zero nor one-hot");

    // a granted word reaches the bus next cycle and needs a free credit
    grant_needs_credit: assert property (@(posedge clk_i) disable iff (rst_i)
        (|grant_i) |-> (int'(held_q) + int'(valid_i) < NCRED))
        else $error("grant issued with no credit left");

    credit_cap: assert property (@(posedge clk_i) disable iff (rst_i)
        cnt_i <= NCNT'(NCRED))
        else $error("credit count above the credit depth");

    valid_after_grant: assert property (@(posedge clk_i) disable iff (rst_i)
        (|grant_i) |=> valid_i)
        else $error("valid_o missing one cycle after a grant");

endmodule

bind acore_bus_arb acore_bus_arb_sva sva0 (
    .clk_i    (ext_clk_i),
    .rst_i    (rst_i),
    .grant_i  (grant_o),
    .valid_i  (valid_o),
    .credit_i (credit_i),
    .cnt_i    (credit_q)
);

/* verilog/analog_core.sv */
module analog_core (
    input  logic                             ext_clk_i,
    input  logic                             rst_i,
    input  logic                             en_i,
    input  logic [acore_pkg::NDIV-1:0]       ndiv_i,
    input  logic signed [acore_pkg::NIN-1:0] rx_sample_i,
    input  logic                             cfg_we_i,
    input  logic [acore_pkg::NID-1:0]        cfg_slice_i,
    input  logic signed [acore_pkg::NIN-1:0] cfg_offset_i,
    input  logic                             credit_i,
    output logic [acore_pkg::NWORD-1:0]      data_o,
    output logic                             valid_o,
    output logic                             overrun_o
);
    import acore_pkg::*;

    logic [NTI-1:0]      strobe;
    logic [NTI-1:0]      req;
    logic [NTI-1:0]      sign;
    logic [NTI*NADC-1:0] adder;    // slice k at bits k*NADC
    logic [NTI-1:0]      grant;
    logic [NTI-1:0]      ovr;

    // sample strobes, one slice per period
    acore_clk_div iindiv (
        .ext_clk_i (ext_clk_i),
        .rst_i     (rst_i),
        .en_i      (en_i),
        .ndiv_i    (ndiv_i),
        .strobe_o  (strobe)
    );

    // 4-way TI ADC
    generate
        for (genvar k = 0; k < NTI; k++) begin : iADC
            acore_adc_slice iADC (
                .ext_clk_i    (ext_clk_i),
                .rst_i        (rst_i),
                .slice_idx_i  (NID'(k)),
                .strobe_i     (strobe[k]),
                .rx_sample_i  (rx_sample_i),
                .cfg_we_i     (cfg_we_i),
                .cfg_slice_i  (cfg_slice_i),
                .cfg_offset_i (cfg_offset_i),
                .grant_i      (grant[k]),
                .req_o        (req[k]),
                .sign_o       (sign[k]),
                .adder_o      (adder[k*NADC +: NADC]),
                .overrun_o    (ovr[k])
            );
        end
    endgenerate

    // result bus to the digital core
    acore_bus_arb iarb (
        .ext_clk_i (ext_clk_i),
        .rst_i     (rst_i),
        .req_i     (req),
        .sign_i    (sign),
        .adder_i   (adder),
        .credit_i  (credit_i),
        .grant_o   (grant),
        .data_o    (data_o),
        .valid_o   (valid_o)
    );

    assign overrun_o = |ovr;   // any slice dropped a sample

endmodule

/* verilog/acore_bus_arb.sv */
module acore_bus_arb (
    input  logic                                       ext_clk_i,
    input  logic                                       rst_i,
    input  logic [acore_pkg::NTI-1:0]                  req_i,
    input  logic [acore_pkg::NTI-1:0]                  sign_i,
    input  logic [acore_pkg::NTI*acore_pkg::NADC-1:0]  adder_i,
    input  logic                                       credit_i,
    output logic [acore_pkg::NTI-1:0]                  grant_o,
    output logic [acore_pkg::NWORD-1:0]                data_o,
    output logic                                       valid_o
);
    import acore_pkg::*;

    logic [NID-1:0]   last_id_q;   // most recent winner
    logic [NID-1:0]   cand;
    logic [NID-1:0]   win_id;
    logic             win_found;
    logic             gnt_en;
    logic [NCNT-1:0]  credit_q;
    logic [NWORD-1:0] data_q;
    logic             valid_q;

    // search starts one past the last winner
    always_comb begin
        win_found = 1'b0;
        win_id    = last_id_q;
        cand      = last_id_q;
        for (int i = 1; i <= NTI; i++) begin
            cand = last_id_q + NID'(i);
            if (!win_found && req_i[cand]) begin
                win_found = 1'b1;
                win_id    = cand;
            end
        end
    end

    assign gnt_en  = win_found && (credit_q != '0);  // hold off without credit
    assign grant_o = gnt_en ? (NTI'(1) << win_id) : '0;

    always_ff @(posedge ext_clk_i) begin
        if (rst_i) begin
            last_id_q <= NID'(NTI - 1);   // slice 0 goes first
            credit_q  <= NCNT'(NCRED);
            valid_q   <= 1'b0;
        end else begin
            credit_q <= credit_q + NCNT'(credit_i) - NCNT'(gnt_en);
            valid_q  <= gnt_en;
            if (gnt_en) begin
                last_id_q <= win_id;
            end
        end
    end

    // word register, loaded only on a grant
    always_ff @(posedge ext_clk_i) begin
        if (gnt_en) begin
            data_q[W_ID_MSB:W_ID_LSB]   <= win_id;
            data_q[W_SIGN_BIT]          <= sign_i[win_id];
            data_q[W_SIGN_BIT-1:W_MAG_LSB] <= adder_i[win_id*NADC +: NADC];
        end
    end

    assign data_o  = data_q;
    assign valid_o = valid_q;

endmodule

/* verilog/acore_adc_slice.sv */
module acore_adc_slice (
    input  logic                             ext_clk_i,
    input  logic                             rst_i,
    input  logic [acore_pkg::NID-1:0]        slice_idx_i,
    input  logic                             strobe_i,
    input  logic signed [acore_pkg::NIN-1:0] rx_sample_i,
    input  logic                             cfg_we_i,
    input  logic [acore_pkg::NID-1:0]        cfg_slice_i,
    input  logic signed [acore_pkg::NIN-1:0] cfg_offset_i,
    input  logic                             grant_i,
    output logic                             req_o,
    output logic                             sign_o,
    output logic [acore_pkg::NADC-1:0]       adder_o,
    output logic                             overrun_o
);
    import acore_pkg::*;

    logic signed [NIN-1:0] offset_q;
    logic signed [NIN:0]   diff;      // one bit wider than the sample
    logic [NIN:0]          diff_abs;
    logic [NADC-1:0]       mag;
    logic                  take;
    logic                  full_q;
    logic                  ovr_q;
    logic                  sign_q;
    logic [NADC-1:0]       mag_q;

    always_ff @(posedge ext_clk_i) begin
        if (rst_i) begin
            offset_q <= '0;
        end else if (cfg_we_i && (cfg_slice_i == slice_idx_i)) begin
            offset_q <= cfg_offset_i;
        end
    end

    // signed operands, extended to NIN+1 by the assignment context
    assign diff     = rx_sample_i - offset_q;
    assign diff_abs = diff[NIN] ? $unsigned(-diff) : $unsigned(diff);
    assign mag      = (|diff_abs[NIN:NADC]) ? MAG_MAX : diff_abs[NADC-1:0];

    // a full hold only makes room when it is granted this cycle
    assign take = strobe_i && !(full_q && !grant_i);

    always_ff @(posedge ext_clk_i) begin
        if (rst_i) begin
            full_q <= 1'b0;
            ovr_q  <= 1'b0;
        end else if (strobe_i && !take) begin
            ovr_q <= 1'b1;   // sample dropped, sticky
        end else if (take) begin
            full_q <= 1'b1;
        end else if (grant_i) begin
            full_q <= 1'b0;
        end
    end

    always_ff @(posedge ext_clk_i) begin
        if (take) begin
            sign_q <= diff[NIN];
            mag_q  <= mag;
        end
    end

    assign req_o     = full_q;
    assign sign_o    = sign_q;
    assign adder_o   = mag_q;
    assign overrun_o = ovr_q;

endmodule

/* verilog/acore_clk_div.sv */
module acore_clk_div (
    input  logic                        ext_clk_i,
    input  logic                        rst_i,
    input  logic                        en_i,
    input  logic [acore_pkg::NDIV-1:0]  ndiv_i,
    output logic [acore_pkg::NTI-1:0]   strobe_o
);
    import acore_pkg::*;

    logic [NDIV-1:0] n_eff;
    logic [NDIV-1:0] cnt_q;
    logic [NTI-1:0]  ptr_q;    // one-hot, next slice to fire
    logic [NTI-1:0]  strobe_q;
    logic            expire;

    assign n_eff  = (ndiv_i == '0) ? NDIV'(1) : ndiv_i;  // 0 behaves as 1
    assign expire = (cnt_q == n_eff - NDIV'(1));

    always_ff @(posedge ext_clk_i) begin
        if (rst_i) begin
            cnt_q    <= '0;
            ptr_q    <= NTI'(1);
            strobe_q <= '0;
        end else if (!en_i) begin
            // disabled, restart from slice 0
            cnt_q    <= '0;
            ptr_q    <= NTI'(1);
            strobe_q <= '0;
        end else if (expire) begin
            cnt_q    <= '0;
            strobe_q <= ptr_q;
            ptr_q    <= {ptr_q[NTI-2:0], ptr_q[NTI-1]};  // hand enable to next slice
        end else begin
            cnt_q    <= cnt_q + NDIV'(1);
            strobe_q <= '0;
        end
    end

    assign strobe_o = strobe_q;

endmodule

/* verilog/acore_pkg.sv */
package acore_pkg;

    localparam int NTI   = 4;               // interleaved slices
    localparam int NADC  = 8;               // magnitude bits
    localparam int NIN   = 9;               // rx sample, two's complement
    localparam int NID   = 2;               // slice id bits
    localparam int NDIV  = 4;               // divider control bits
    localparam int NWORD = NID + 1 + NADC;  // id, sign, magnitude
    localparam int NCRED = 4;               // credits held by the digital core
    localparam int NCNT  = 3;               // credit counter bits

    // result word layout, msb first
    localparam int W_MAG_LSB  = 0;
    localparam int W_SIGN_BIT = NADC;
    localparam int W_ID_LSB   = NADC + 1;
    localparam int W_ID_MSB   = NWORD - 1;

    // full scale magnitude
    localparam logic [NADC-1:0] MAG_MAX = '1;

endpackage
